//--- compile.f
verilog/accelPkg.sv
verilog/prefixAndOr.sv
verilog/addC.sv
verilog/adderArbiter.sv
verilog/wordAccumulator.sv
verilog/axiLiteRegs.sv
verilog/accelTop.sv
verif/accelTb.sv

//--- verif/accelTb.sv
`timescale 1ns/10ps

module accelTb import accelPkg::*; ();

	// ~60 accumulates under 40 cycles each plus register traffic, with margin
	localparam int cycleLimit = 5000;

	logic                 clk;
	logic                 reset;
	logic                 awvalid;
	logic                 awready;
	logic [addrWidth-1:0] awaddr;
	logic                 wvalid;
	logic                 wready;
	logic [wordWidth-1:0] wdata;
	logic                 bvalid;
	logic                 bready;
	logic [1:0]           bresp;
	logic                 arvalid;
	logic                 arready;
	logic [addrWidth-1:0] araddr;
	logic                 rvalid;
	logic                 rready;
	logic [wordWidth-1:0] rdata;
	logic [1:0]           rresp;

	logic [accWidth-1:0]  modelSum [2]; // expected running sums
	logic                 modelOvf [2]; // expected sticky overflow
	logic [accWidth-1:0]  modelOp [2];  // operand last loaded per channel
	logic [wordWidth-1:0] readWord;
	logic [accWidth-1:0]  op0;
	logic [accWidth-1:0]  op1;
	integer               seed;
	int                   cycleCount;
	string                testName;

	accelTop accelTop_inst (.*);

	always #2 clk = ~clk; // 4 ns period

	// hard stop if a handshake never completes
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout after %0d cycles in test %s", cycleCount, testName);
			$display("Simulation failed");
			$fatal(1, "run did not finish in time");
		end
	end

	// plain 129 bit addition, carry out in the top bit
	function automatic logic [accWidth:0] refAccumulate(input logic [accWidth-1:0] oldSum,
			input logic [accWidth-1:0] operand);
		refAccumulate = {1'b0, oldSum} + {1'b0, operand};
	endfunction

	task automatic compareWord(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s %s: expected %h, actual %h", testName, what, expected, actual);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// called right after a falling edge, returns right after one
	task automatic axiWrite(input logic [addrWidth-1:0] addr, input logic [wordWidth-1:0] data,
			input int holdB);
		awvalid = 1'b1;
		awaddr  = addr;
		wvalid  = 1'b1;
		wdata   = data;
		@(negedge clk);
		while (!awready) @(negedge clk);
		compareWord("wready", 32'(1), 32'(wready)); // aw and w taken together
		@(negedge clk); // accepted on the edge just passed
		awvalid = 1'b0;
		wvalid  = 1'b0;
		repeat (holdB) begin
			compareWord("bvalid held", 32'(1), 32'(bvalid)); // response must wait for bready
			@(negedge clk);
		end
		while (!bvalid) @(negedge clk);
		compareWord("bresp", 32'(respOkay), 32'(bresp));
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axiRead(input logic [addrWidth-1:0] addr, output logic [wordWidth-1:0] data,
			input int holdR);
		logic [wordWidth-1:0] firstData;
		arvalid = 1'b1;
		araddr  = addr;
		@(negedge clk);
		while (!arready) @(negedge clk);
		@(negedge clk);
		arvalid = 1'b0;
		araddr  = '0; // address gone, rdata must stay latched
		while (!rvalid) @(negedge clk);
		firstData = rdata;
		repeat (holdR) begin
			@(negedge clk);
			compareWord("rvalid held", 32'(1), 32'(rvalid));
			compareWord("rdata held", firstData, rdata); // stalled data must not move
		end
		compareWord("rresp", 32'(respOkay), 32'(rresp));
		data   = rdata;
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic loadOperand(input int ch, input logic [accWidth-1:0] op, input int holdB);
		logic [addrWidth-1:0] base;
		base = ch ? regOperand1 : regOperand0;
		for (int w = 0; w < numWords; w++) begin
			axiWrite(base + addrWidth'(4 * w), op[w*wordWidth +: wordWidth], w == 0 ? holdB : 0);
		end
		modelOp[ch] = op;
	endtask

	// mask bit 0 starts channel 0, bit 1 channel 1, in one ctrl write
	task automatic startChannels(input logic [1:0] mask);
		logic [accWidth:0] result;
		axiWrite(regCtrl, 32'(mask), 0);
		for (int c = 0; c < 2; c++) begin
			if (mask[c]) begin
				result      = refAccumulate(modelSum[c], modelOp[c]);
				modelSum[c] = result[accWidth-1:0];
				modelOvf[c] = modelOvf[c] | result[accWidth];
			end
		end
	endtask

	task automatic clearChannel(input int ch);
		axiWrite(regCtrl, 32'(4 << ch), 0); // bits 2 and 3 clear
		modelSum[ch] = '0;
		modelOvf[ch] = 1'b0;
	endtask

	task automatic pollIdle(input int ch);
		logic [wordWidth-1:0] status;
		axiRead(regStatus, status, 0);
		while (status[ch]) axiRead(regStatus, status, 0);
	endtask

	// read back one channel and compare against the model
	task automatic checkValue(input int ch);
		logic [wordWidth-1:0] word;
		logic [addrWidth-1:0] base;
		base = ch ? regSum1 : regSum0;
		for (int w = 0; w < numWords; w++) begin
			axiRead(base + addrWidth'(4 * w), word, 0);
			compareWord($sformatf("ch%0d sum word %0d", ch, w),
				modelSum[ch][w*wordWidth +: wordWidth], word);
		end
		axiRead(regStatus, word, 0);
		compareWord($sformatf("ch%0d busy", ch), 32'(0), 32'(word[ch]));
		compareWord($sformatf("ch%0d overflow", ch), 32'(modelOvf[ch]), 32'(word[ch+2]));
	endtask

	task automatic randomOperand(output logic [accWidth-1:0] op);
		for (int w = 0; w < numWords; w++) begin
			op[w*wordWidth +: wordWidth] = $random(seed);
		end
	endtask

	initial begin
		clk        = 1'b0;
		reset      = 1'b1;
		awvalid    = 1'b0;
		awaddr     = '0;
		wvalid     = 1'b0;
		wdata      = '0;
		bready     = 1'b0;
		arvalid    = 1'b0;
		araddr     = '0;
		rready     = 1'b0;
		seed       = 32'h5e0f;
		cycleCount = 0;
		testName   = "reset";
		for (int c = 0; c < 2; c++) begin
			modelSum[c] = '0;
			modelOvf[c] = 1'b0;
			modelOp[c]  = '0;
		end
		repeat (2) @(negedge clk);
		reset = 1'b0;

		// everything reads zero out of reset
		axiRead(regStatus, readWord, 0);
		compareWord("status", 32'(0), readWord);
		checkValue(0);
		checkValue(1);

		testName = "carryChain";
		loadOperand(0, 128'h1, 0);
		startChannels(2'b01);
		pollIdle(0);
		checkValue(0);
		loadOperand(0, 128'h00000000_ffffffff_ffffffff_ffffffff, 0); // ripples into word 3
		startChannels(2'b01);
		pollIdle(0);
		checkValue(0);

		testName = "overflow";
		loadOperand(1, {accWidth{1'b1}}, 0);
		startChannels(2'b10);
		pollIdle(1);
		checkValue(1);
		loadOperand(1, 128'h2, 0); // wraps past 2**128
		startChannels(2'b10);
		pollIdle(1);
		checkValue(1);
		loadOperand(1, 128'h5, 0);
		startChannels(2'b10);
		pollIdle(1);
		checkValue(1); // flag sticks
		clearChannel(1);
		checkValue(1);

		testName = "bothChannels";
		loadOperand(0, 128'hdeadbeef_01234567_89abcdef_ffffffff, 0);
		loadOperand(1, 128'h0f0f0f0f_f0f0f0f0_ffffffff_00000001, 0);
		startChannels(2'b11);
		pollIdle(0);
		pollIdle(1);
		checkValue(0);
		checkValue(1);

		testName = "random";
		for (int i = 0; i < 20; i++) begin
			randomOperand(op0);
			randomOperand(op1);
			loadOperand(0, op0, 0);
			loadOperand(1, op1, 0);
			case (i % 3)
				0: begin
					startChannels(2'b01);
					startChannels(2'b10);
				end
				1: startChannels(2'b11); // same write, arbiter alternates
				default: begin
					startChannels(2'b10);
					startChannels(2'b01);
				end
			endcase
			pollIdle(0);
			pollIdle(1);
			checkValue(0);
			checkValue(1);
		end

		testName = "backPressure";
		randomOperand(op0);
		loadOperand(0, op0, 6); // bready low for six cycles on the first word
		startChannels(2'b01);
		pollIdle(0);
		axiRead(regSum0, readWord, 6); // rready low for six cycles
		compareWord("stalled sum word 0", modelSum[0][wordWidth-1:0], readWord);
		checkValue(0);

		$display("Simulation passed");
		$finish;
	end

endmodule

//--- verilog/accelPkg.sv
package accelPkg;

	localparam int wordWidth  = 32;                     // axi data and adder width
	localparam int numWords   = 4;                      // words per accumulator
	localparam int accWidth   = numWords * wordWidth;   // running sum width
	localparam int idxWidth   = $clog2(numWords);       // word index bits
	localparam int adderSpeed = 2;                      // 0 serial, 1 brent-kung, 2 sklansky
	localparam int addrWidth  = 8;

	localparam logic [1:0] respOkay = 2'b00;

	// register map, byte addresses
	localparam logic [addrWidth-1:0] regCtrl     = 8'h00; // start and clear bits
	localparam logic [addrWidth-1:0] regStatus   = 8'h04; // busy and overflow
	localparam logic [addrWidth-1:0] regOperand0 = 8'h10; // four words, lsw first
	localparam logic [addrWidth-1:0] regOperand1 = 8'h20;
	localparam logic [addrWidth-1:0] regSum0     = 8'h30; // read only
	localparam logic [addrWidth-1:0] regSum1     = 8'h40; // read only

endpackage

//--- verilog/accelTop.sv
`timescale 1ns/10ps

module accelTop import accelPkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 awvalid,
	output logic                 awready,
	input  logic [addrWidth-1:0] awaddr,
	input  logic                 wvalid,
	output logic                 wready,
	input  logic [wordWidth-1:0] wdata,
	output logic                 bvalid,
	input  logic                 bready,
	output logic [1:0]           bresp,
	input  logic                 arvalid,
	output logic                 arready,
	input  logic [addrWidth-1:0] araddr,
	output logic                 rvalid,
	input  logic                 rready,
	output logic [wordWidth-1:0] rdata,
	output logic [1:0]           rresp
);

	// register block to channels
	logic                start0, start1;
	logic                clear0, clear1;
	logic [accWidth-1:0] operand0, operand1;
	logic                busy0, busy1;
	logic                overflow0, overflow1;
	logic [accWidth-1:0] accum0, accum1;

	// channels to arbiter
	logic                 req0, req1;
	logic [wordWidth-1:0] reqA0, reqA1;
	logic [wordWidth-1:0] reqB0, reqB1;
	logic                 reqCi0, reqCi1;
	logic                 grant0, grant1;
	logic [wordWidth-1:0] sum; // shared adder result
	logic                 co;

	axiLiteRegs regs (
		.clk(clk), .reset(reset),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.start0(start0), .start1(start1), .clear0(clear0), .clear1(clear1),
		.operand0(operand0), .operand1(operand1),
		.busy0(busy0), .busy1(busy1),
		.overflow0(overflow0), .overflow1(overflow1),
		.accum0(accum0), .accum1(accum1)
	);

	wordAccumulator chan0 (
		.clk(clk), .reset(reset), .start(start0), .clear(clear0),
		.operand(operand0), .grant(grant0), .sum(sum), .co(co),
		.req(req0), .reqA(reqA0), .reqB(reqB0), .reqCi(reqCi0),
		.busy(busy0), .overflow(overflow0), .accum(accum0)
	);

	wordAccumulator chan1 (
		.clk(clk), .reset(reset), .start(start1), .clear(clear1),
		.operand(operand1), .grant(grant1), .sum(sum), .co(co),
		.req(req1), .reqA(reqA1), .reqB(reqB1), .reqCi(reqCi1),
		.busy(busy1), .overflow(overflow1), .accum(accum1)
	);

	adderArbiter arbiter (
		.clk(clk), .reset(reset),
		.req0(req0), .req1(req1),
		.a0(reqA0), .b0(reqB0), .ci0(reqCi0),
		.a1(reqA1), .b1(reqB1), .ci1(reqCi1),
		.grant0(grant0), .grant1(grant1),
		.sum(sum), .co(co)
	);

endmodule

//--- verilog/addC.sv
`timescale 1ns/10ps

module addC #(
	parameter int width = 8, // operand width
	parameter int speed = 0  // prefix structure select
) (
	input  logic [width-1:0] A,
	input  logic [width-1:0] B,
	input  logic             CI, // carry in
	output logic [width-1:0] S,  // A+B+CI
	output logic             CO  // carry out of top bit
);

	logic [width-1:0] genIn;   // per bit generate
	logic [width-1:0] propIn;  // per bit propagate
	logic [width-1:0] genOut;  // carry out of each bit position
	logic [width-1:0] halfSum; // A xor B

	assign halfSum = A ^ B;

	// bit 0 absorbs the carry in, so its generate is a majority
	assign genIn[0]  = (A[0] & B[0]) | (A[0] & CI) | (B[0] & CI);
	assign propIn[0] = 1'b0; // nothing ripples past bit 0 from below

	for (genvar i = 1; i < width; i++) begin : preprocess
		assign genIn[i]  = A[i] & B[i];
		assign propIn[i] = A[i] | B[i];
	end

	prefixAndOr #(
		.width(width),
		.speed(speed)
	) prefix (
		.GI(genIn),
		.PI(propIn),
		.GO(genOut),
		.PO()      // group propagate unused once ci sits in bit 0
	);

	assign S  = halfSum ^ {genOut[width-2:0], CI}; // carry into bit i is carry out of i-1
	assign CO = genOut[width-1];

endmodule

//--- verilog/adderArbiter.sv
`timescale 1ns/10ps

module adderArbiter import accelPkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 req0,   // channel 0 wants the adder
	input  logic                 req1,
	input  logic [wordWidth-1:0] a0,     // channel 0 sum word
	input  logic [wordWidth-1:0] b0,     // channel 0 operand word
	input  logic                 ci0,
	input  logic [wordWidth-1:0] a1,
	input  logic [wordWidth-1:0] b1,
	input  logic                 ci1,
	output logic                 grant0,
	output logic                 grant1,
	output logic [wordWidth-1:0] sum,    // seen by both channels
	output logic                 co
);

	logic                 lastGrant; // set when channel 1 won last
	logic [wordWidth-1:0] opA;
	logic [wordWidth-1:0] opB;
	logic                 opCi;

	// lone requester always wins, on a tie the other channel from last time
	assign grant0 = req0 && (!req1 || lastGrant);
	assign grant1 = req1 && (!req0 || !lastGrant);

	always_ff @(posedge clk) begin
		if (reset) begin
			lastGrant <= 1'b1; // channel 0 first after reset
		end else if (grant0 || grant1) begin
			lastGrant <= grant1;
		end
	end

	// steer the winner into the one adder
	assign opA  = grant1 ? a1 : a0;
	assign opB  = grant1 ? b1 : b0;
	assign opCi = grant1 ? ci1 : ci0;

	addC #(
		.width(wordWidth),
		.speed(adderSpeed)
	) adder (
		.A(opA),
		.B(opB),
		.CI(opCi),
		.S(sum),
		.CO(co)
	);

endmodule

//--- verilog/axiLiteRegs.sv
`timescale 1ns/10ps

module axiLiteRegs import accelPkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 awvalid,
	output logic                 awready,
	input  logic [addrWidth-1:0] awaddr,
	input  logic                 wvalid,
	output logic                 wready,
	input  logic [wordWidth-1:0] wdata,
	output logic                 bvalid,
	input  logic                 bready,
	output logic [1:0]           bresp,
	input  logic                 arvalid,
	output logic                 arready,
	input  logic [addrWidth-1:0] araddr,
	output logic                 rvalid,
	input  logic                 rready,
	output logic [wordWidth-1:0] rdata,
	output logic [1:0]           rresp,
	output logic                 start0,
	output logic                 start1,
	output logic                 clear0,
	output logic                 clear1,
	output logic [accWidth-1:0]  operand0,
	output logic [accWidth-1:0]  operand1,
	input  logic                 busy0,
	input  logic                 busy1,
	input  logic                 overflow0,
	input  logic                 overflow1,
	input  logic [accWidth-1:0]  accum0,
	input  logic [accWidth-1:0]  accum1
);

	logic                          wrReady; // aw and w accepted together
	logic                          wrFire;
	logic                          rdFire;
	logic                          ctrlHit; // write lands on regCtrl
	logic [addrWidth-idxWidth-3:0] wrBlock; // 16 byte block number
	logic [addrWidth-idxWidth-3:0] rdBlock;
	logic [idxWidth-1:0]           wrIdx;   // word within block
	logic [idxWidth-1:0]           rdIdx;
	logic [wordWidth-1:0]          rdWord;  // read mux out

	assign awready = wrReady;
	assign wready  = wrReady;
	assign wrFire  = wrReady && awvalid && wvalid;
	assign rdFire  = arready && arvalid;
	assign bresp   = respOkay; // never an error
	assign rresp   = respOkay;

	assign wrBlock = awaddr[addrWidth-1:idxWidth+2];
	assign rdBlock = araddr[addrWidth-1:idxWidth+2];
	assign wrIdx   = awaddr[idxWidth+1:2];
	assign rdIdx   = araddr[idxWidth+1:2];
	assign ctrlHit = wrFire && (awaddr[addrWidth-1:2] == regCtrl[addrWidth-1:2]);

	// write side, one transaction in flight
	always_ff @(posedge clk) begin
		if (reset) begin
			wrReady <= 1'b0;
			bvalid  <= 1'b0;
			start0  <= 1'b0;
			start1  <= 1'b0;
			clear0  <= 1'b0;
			clear1  <= 1'b0;
		end else begin
			wrReady <= awvalid && wvalid && !wrReady && !bvalid;
			if (wrFire) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0; // held while bready is low
			end
			start0 <= ctrlHit && wdata[0]; // pulses one cycle after accept
			start1 <= ctrlHit && wdata[1];
			clear0 <= ctrlHit && wdata[2];
			clear1 <= ctrlHit && wdata[3];
		end
	end

	// operand words
	always_ff @(posedge clk) begin
		if (wrFire && wrBlock == regOperand0[addrWidth-1:idxWidth+2]) begin
			operand0[wrIdx*wordWidth +: wordWidth] <= wdata;
		end
		if (wrFire && wrBlock == regOperand1[addrWidth-1:idxWidth+2]) begin
			operand1[wrIdx*wordWidth +: wordWidth] <= wdata;
		end
	end

	always_comb begin
		case (rdBlock)
			regOperand0[addrWidth-1:idxWidth+2]: rdWord = operand0[rdIdx*wordWidth +: wordWidth];
			regOperand1[addrWidth-1:idxWidth+2]: rdWord = operand1[rdIdx*wordWidth +: wordWidth];
			regSum0[addrWidth-1:idxWidth+2]:     rdWord = accum0[rdIdx*wordWidth +: wordWidth];
			regSum1[addrWidth-1:idxWidth+2]:     rdWord = accum1[rdIdx*wordWidth +: wordWidth];
			default:                             rdWord = '0; // unmapped, ctrl too
		endcase
		if (araddr[addrWidth-1:2] == regStatus[addrWidth-1:2]) begin
			rdWord = wordWidth'({overflow1, overflow0, busy1, busy0});
		end
	end

	// read side
	always_ff @(posedge clk) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			arready <= arvalid && !arready && !rvalid;
			if (rdFire) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rdFire) rdata <= rdWord; // frozen until rready
	end

endmodule

//--- verilog/prefixAndOr.sv
`timescale 1ns/10ps

module prefixAndOr #(
	parameter int width = 8, // bits in the network
	parameter int speed = 0  // 0 serial, 1 brent-kung, 2 sklansky
) (
	input  logic [width-1:0] GI, // bit generate
	input  logic [width-1:0] PI, // bit propagate
	output logic [width-1:0] GO, // group generate from bit 0 up
	output logic [width-1:0] PO  // group propagate from bit 0 up
);

	localparam int n = width;
	localparam int m = $clog2(width); // tree depth

	// combine node is (g,p) o (g',p') = (g | p&g', p&p'), primed side lower

	if (speed == 2) begin : fastPrefix
		// sklansky, m levels, high fanout
		logic [n-1:0] gT [0:m]; // one row per level
		logic [n-1:0] pT [0:m];

		assign gT[0] = GI;
		assign pT[0] = PI;

		for (genvar l = 1; l <= m; l++) begin : levels
			for (genvar j = 0; j < n; j++) begin : bits
				// upper half of each 2**l group takes the top bit of its lower half
				if (j % 2**l >= 2**(l-1)) begin : black
					localparam int src = (j / 2**l) * 2**l + 2**(l-1) - 1;
					assign gT[l][j] = gT[l-1][j] | (pT[l-1][j] & gT[l-1][src]);
					assign pT[l][j] = pT[l-1][j] & pT[l-1][src];
				end else begin : white
					assign gT[l][j] = gT[l-1][j];
					assign pT[l][j] = pT[l-1][j];
				end
			end
		end

		assign GO = gT[m];
		assign PO = pT[m];
	end else if (speed == 1) begin : mediumPrefix
		// brent-kung, up-sweep of m rows then down-sweep of m-1 rows
		logic [n-1:0] gT [0:2*m-1];
		logic [n-1:0] pT [0:2*m-1];

		assign gT[0] = GI;
		assign pT[0] = PI;

		for (genvar l = 1; l <= m; l++) begin : upLevels
			for (genvar j = 0; j < n; j++) begin : bits
				if (j % 2**l == 2**l - 1) begin : black // group tops only
					localparam int src = j - 2**(l-1);
					assign gT[l][j] = gT[l-1][j] | (pT[l-1][j] & gT[l-1][src]);
					assign pT[l][j] = pT[l-1][j] & pT[l-1][src];
				end else begin : white
					assign gT[l][j] = gT[l-1][j];
					assign pT[l][j] = pT[l-1][j];
				end
			end
		end

		for (genvar d = 1; d < m; d++) begin : downLevels
			localparam int s = 2**(m-d); // span shrinks each row
			for (genvar j = 0; j < n; j++) begin : bits
				// mid points pick up the finished prefix just below their group
				if (j >= s && j % s == s/2 - 1) begin : black
					localparam int src = j - s/2;
					assign gT[m+d][j] = gT[m+d-1][j] | (pT[m+d-1][j] & gT[m+d-1][src]);
					assign pT[m+d][j] = pT[m+d-1][j] & pT[m+d-1][src];
				end else begin : white
					assign gT[m+d][j] = gT[m+d-1][j];
					assign pT[m+d][j] = pT[m+d-1][j];
				end
			end
		end

		assign GO = gT[2*m-1];
		assign PO = pT[2*m-1];
	end else begin : slowPrefix
		// ripple chain, n-1 nodes deep
		assign GO[0] = GI[0];
		assign PO[0] = PI[0];
		for (genvar i = 1; i < n; i++) begin : bits
			assign GO[i] = GI[i] | (PI[i] & GO[i-1]);
			assign PO[i] = PI[i] & PO[i-1];
		end
	end

endmodule

//--- verilog/wordAccumulator.sv
`timescale 1ns/10ps

module wordAccumulator import accelPkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 start,    // one cycle pulse
	input  logic                 clear,    // one cycle pulse
	input  logic [accWidth-1:0]  operand,
	input  logic                 grant,    // adder is ours this cycle
	input  logic [wordWidth-1:0] sum,
	input  logic                 co,
	output logic                 req,
	output logic [wordWidth-1:0] reqA,
	output logic [wordWidth-1:0] reqB,
	output logic                 reqCi,
	output logic                 busy,
	output logic                 overflow, // sticky top carry
	output logic [accWidth-1:0]  accum
);

	logic [accWidth-1:0] opReg;   // operand copy held for the whole run
	logic [idxWidth-1:0] wordIdx; // word now in the adder
	logic                carry;   // carry between words
	logic                lastWord;

	assign lastWord = (wordIdx == idxWidth'(numWords - 1));

	// request holds steady until granted since state only moves on grant
	assign req   = busy;
	assign reqA  = accum[wordIdx*wordWidth +: wordWidth];
	assign reqB  = opReg[wordIdx*wordWidth +: wordWidth];
	assign reqCi = carry;

	always_ff @(posedge clk) begin
		if (start && !busy) opReg <= operand;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy     <= 1'b0;
			wordIdx  <= '0;
			carry    <= 1'b0;
			overflow <= 1'b0;
			accum    <= '0;
		end else if (busy) begin
			// start and clear are ignored mid run
			if (grant) begin
				accum[wordIdx*wordWidth +: wordWidth] <= sum;
				carry   <= co;
				wordIdx <= wordIdx + 1'b1;
				if (lastWord) begin
					busy     <= 1'b0;
					overflow <= overflow | co; // carry out of bit 127
				end
			end
		end else begin
			if (clear) begin
				accum    <= '0;
				overflow <= 1'b0;
			end
			if (start) begin
				busy    <= 1'b1;
				carry   <= 1'b0;
				wordIdx <= '0; // lowest word first
			end
		end
	end

endmodule
